// ==== project.f ====
hw/taylor_pkg.sv
hw/taylor_coef_rom.sv
hw/dsp_mac.sv
hw/taylor_sequencer.sv
hw/taylor_wb_regs.sv
hw/taylor_unit_top.sv
testbench/tb_clock_gen.sv
testbench/taylor_unit_properties.sv
testbench/taylor_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module taylor_unit_tb \
    -f project.f \
    --Mdir build_sim \
    -o taylor_unit_sim

./build_sim/taylor_unit_sim

// ==== testbench/taylor_unit_tb.sv ====
`timescale 1ns/1ps

module taylor_unit_tb
    import taylor_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY  = 2;
    localparam int N_DIRECTED   = 20;
    localparam int N_RESERVED   = 4;
    localparam int N_RANDOM     = 12;
    localparam int N_ENTRIES    = N_DIRECTED + N_RESERVED + N_RANDOM;
    // Two extra runs for the readback and busy-start checks
    localparam int TIMEOUT_CYCLES = 200 * (N_ENTRIES + 2) + RESET_CYCLES;

    localparam logic [31:0] START_CMD = 32'd1 << CTRL_START_BIT;
    localparam fix_t DIRECTED_X [0:4] = '{18'sh00000, 18'sh08000, -18'sh08000,
                                          18'sh10000, -18'sh10000};

    typedef struct packed {
        logic [2:0] func;
        fix_t       x;
        logic       expect_zero;
        fix_t       expected;
    } stim_t;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    stim_t       stim [0:N_ENTRIES-1];
    int          cycle_count;
    int          done_pulses;

    tb_clock_gen #(.PERIOD_NS(40)) clk_gen0 (.clk(clk));

    taylor_unit_top #(.ACC_W(48)) dut0 (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    function automatic int sign_of(input logic [2:0] func, input int n);
        int s;
        s = 0;
        case (func)
            FN_SIN:  s = (n % 4 == 1) ? 1 : ((n % 4 == 3) ? -1 : 0);
            FN_COS:  s = (n % 4 == 0) ? 1 : ((n % 4 == 2) ? -1 : 0);
            FN_SINH: s = (n % 2 == 1) ? 1 : 0;
            FN_COSH: s = (n % 2 == 0) ? 1 : 0;
            default: s = 0;
        endcase
        return s;
    endfunction

    function automatic fix_t recip_of(input int n);
        if (n == 0) begin
            return FIX_ONE;
        end
        return fix_t'(int'(FIX_ONE) / n);
    endfunction

    function automatic fix_t model_eval(input logic [2:0] func, input fix_t x);
        fix_t   r [0:N_TERMS];
        fix_t   term [0:N_TERMS];
        longint prod;
        longint acc;
        int     n;
        r[0] = '0;
        for (n = 1; n <= N_TERMS; n++) begin
            prod = longint'(x) * longint'(recip_of(n));
            r[n] = fix_t'(prod >>> 16);
        end
        term[0] = FIX_ONE;
        for (n = 1; n <= N_TERMS; n++) begin
            prod    = longint'(term[n-1]) * longint'(r[n]);
            term[n] = fix_t'(prod >>> 16);
        end
        acc = 0;
        for (n = 0; n <= N_TERMS; n++) begin
            acc = acc + longint'(sign_of(func, n)) * longint'(FIX_ONE) * longint'(term[n]);
        end
        return fix_t'(acc >>> 16);
    endfunction

    function automatic logic [31:0] to_word(input fix_t v);
        return {{14{v[17]}}, v};
    endfunction

    // ------------------------------------------------------------------------
    // Checking and bus access
    // ------------------------------------------------------------------------

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t: %s: got %08h, expected %08h",
                     $time, what, got, expected);
            $display("Regression failed");
            $fatal(1, "Value mismatch in %s", what);
        end
    endtask

    task automatic bus_cycle(input logic write, input logic [1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = write;
        wb_adr   = addr;
        wb_dat_w = wdata;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        rdata = wb_dat_r;
        @(posedge clk);
        #DRIVE_DELAY;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic reg_write(input logic [1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic reg_read(input logic [1:0] addr, output logic [31:0] data);
        bus_cycle(1'b0, addr, 32'd0, data);
    endtask

    task automatic wait_done(output logic [31:0] status);
        status = '0;
        while (!status[STAT_DONE_BIT]) begin
            reg_read(REG_STATUS, status);
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequences
    // ------------------------------------------------------------------------

    task automatic build_table();
        int n;
        int f;
        int i;
        int x_int;
        n = 0;
        for (f = 0; f < 4; f++) begin
            for (i = 0; i < 5; i++) begin
                stim[n].func = 3'(f);
                stim[n].x    = DIRECTED_X[i];
                // sin and sinh vanish at zero
                stim[n].expect_zero = (DIRECTED_X[i] == 0) && (f == 0 || f == 2);
                n++;
            end
        end
        for (f = 4; f < 8; f++) begin
            stim[n].func        = 3'(f);
            stim[n].x           = 18'sh0c000;
            stim[n].expect_zero = 1'b1;
            n++;
        end
        for (f = 0; f < 4; f++) begin
            for (i = 0; i < 3; i++) begin
                x_int = int'($urandom % 32'd131073) - 65536;
                stim[n].func        = 3'(f);
                stim[n].x           = fix_t'(x_int);
                stim[n].expect_zero = 1'b0;
                n++;
            end
        end
        for (n = 0; n < N_ENTRIES; n++) begin
            stim[n].expected = stim[n].expect_zero ? '0 : model_eval(stim[n].func, stim[n].x);
        end
    endtask

    task automatic check_after_reset();
        logic [31:0] data;
        reg_read(REG_STATUS, data);
        check_value("status after reset", data, 32'd0);
        reg_read(REG_RESULT, data);
        check_value("result after reset", data, 32'd0);
    endtask

    task automatic check_readback_and_status();
        logic [31:0] data;
        fix_t        x;
        x = -18'sh0c000;
        reg_write(REG_X, to_word(x));
        reg_read(REG_X, data);
        check_value("operand readback", data, to_word(x));
        reg_write(REG_CTRL, 32'(FN_COSH));
        reg_read(REG_CTRL, data);
        check_value("control readback", data, 32'(FN_COSH));
        reg_write(REG_CTRL, START_CMD | 32'(FN_COSH));
        reg_read(REG_STATUS, data);
        check_value("status while running", {30'd0, data[1:0]}, 32'd1);
        wait_done(data);
        check_value("status at done", {30'd0, data[1:0]}, 32'd2);
        reg_read(REG_RESULT, data);
        check_value("cosh result", data, to_word(model_eval(FN_COSH, x)));
    endtask

    task automatic check_busy_start();
        logic [31:0] data;
        int          pulses_before;
        fix_t        x_first;
        x_first       = 18'sh0a000;
        pulses_before = done_pulses;
        reg_write(REG_X, to_word(x_first));
        reg_write(REG_CTRL, START_CMD | 32'(FN_SIN));
        // Second request lands while the first is running
        reg_write(REG_X, to_word(-18'sh04000));
        reg_write(REG_CTRL, START_CMD | 32'(FN_COS));
        wait_done(data);
        check_value("busy after ignored start", {31'd0, data[STAT_BUSY_BIT]}, 32'd0);
        reg_read(REG_CTRL, data);
        check_value("function kept during run", data, 32'(FN_SIN));
        reg_read(REG_RESULT, data);
        check_value("result of first request", data, to_word(model_eval(FN_SIN, x_first)));
        check_value("done pulse count", 32'(done_pulses - pulses_before), 32'd1);
    endtask

    task automatic run_entry(input int k);
        logic [31:0] status;
        logic [31:0] data;
        reg_write(REG_X, to_word(stim[k].x));
        reg_write(REG_CTRL, START_CMD | {29'd0, stim[k].func});
        wait_done(status);
        check_value($sformatf("busy at done, entry %0d", k),
                    {31'd0, status[STAT_BUSY_BIT]}, 32'd0);
        reg_read(REG_RESULT, data);
        check_value($sformatf("result of entry %0d", k), data, to_word(stim[k].expected));
    endtask

    // ------------------------------------------------------------------------
    // Monitors and main sequence
    // ------------------------------------------------------------------------

    always @(negedge clk) begin
        if (dut0.done) begin
            done_pulses = done_pulses + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_count);
            $display("Regression failed");
            $fatal(1, "Simulation timed out");
        end
    end

    initial begin
        int k;
        void'($urandom(32'h7d33));
        cycle_count = 0;
        done_pulses = 0;
        reset       = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        check_after_reset();
        check_readback_and_status();
        check_busy_start();
        for (k = 0; k < N_ENTRIES; k++) begin
            run_entry(k);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== testbench/taylor_unit_properties.sv ====
`timescale 1ns/1ps

module taylor_unit_properties (
    input logic clk,
    input logic reset,
    input logic wb_stb,
    input logic wb_ack,
    input logic busy,
    input logic done,
    input logic start
);

    // Ack only ever answers a strobe
    ack_needs_stb: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> wb_stb)
        else $error("ack seen without stb");

    // Done pulse closes a run
    done_after_busy: assert property (@(posedge clk) disable iff (reset)
        done |-> $past(busy))
        else $error("done without busy in the previous cycle");

    // Control writes during a run never reach the sequencer
    no_start_when_busy: assert property (@(posedge clk) disable iff (reset)
        start |-> !busy)
        else $error("start issued while busy");

endmodule

bind taylor_unit_top taylor_unit_properties props0 (
    .clk    (clk),
    .reset  (reset),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .busy   (busy),
    .done   (done),
    .start  (start)
);

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2);
        clk = ~clk;
    end

endmodule

// ==== hw/taylor_unit_top.sv ====
`timescale 1ns/1ps

module taylor_unit_top
    import taylor_pkg::*;
#(
    parameter int ACC_W = 48
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:2]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    logic       start;
    calc_req_t  req;
    logic       busy;
    logic       done;
    fix_t       result;
    logic [3:0] coef_idx;
    fix_t       coef;
    fix_t       recip;
    mac_in_t    mac_in;
    mac_out_t   mac_out;

    taylor_wb_regs regs0 (
        .clk    (clk),
        .reset  (reset),
        .cyc    (wb_cyc),
        .stb    (wb_stb),
        .we     (wb_we),
        .adr    (wb_adr),
        .dat_w  (wb_dat_w),
        .dat_r  (wb_dat_r),
        .ack    (wb_ack),
        .busy   (busy),
        .done   (done),
        .result (result),
        .start  (start),
        .req    (req)
    );

    taylor_sequencer #(.ACC_W(ACC_W)) seq0 (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .req      (req),
        .coef     (coef),
        .recip    (recip),
        .coef_idx (coef_idx),
        .mac_in   (mac_in),
        .mac_out  (mac_out),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

    // Function code is held in the register block for the whole run
    taylor_coef_rom rom0 (
        .func  (req.func),
        .idx   (coef_idx),
        .coef  (coef),
        .recip (recip)
    );

    dsp_mac #(.ACC_W(ACC_W)) mac0 (
        .clk     (clk),
        .reset   (reset),
        .mac_in  (mac_in),
        .mac_out (mac_out)
    );

endmodule

// ==== hw/taylor_wb_regs.sv ====
`timescale 1ns/1ps

module taylor_wb_regs
    import taylor_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [1:0]  adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack,
    input  logic        busy,
    input  logic        done,
    input  fix_t        result,
    output logic        start,
    output calc_req_t   req
);

    logic        bus_req;
    logic        wr_en;
    logic        ctrl_wr;
    func_e       func_q;
    fix_t        x_q;
    logic        done_flag;
    fix_t        result_q;
    logic [31:0] rd_data;

    assign bus_req = cyc && stb && !ack;
    assign wr_en   = bus_req && we;
    // Control writes are dropped while a calculation runs
    assign ctrl_wr = wr_en && (adr == REG_CTRL) && !busy;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= bus_req;
        end
    end

    // ------------------------------------------------------------------------
    // Register writes and start pulse
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start  <= 1'b0;
            func_q <= FN_SIN;
            x_q    <= '0;
        end else begin
            start <= ctrl_wr && dat_w[CTRL_START_BIT];
            if (ctrl_wr) begin
                func_q <= func_e'(dat_w[2:0]);
            end
            if (wr_en && (adr == REG_X)) begin
                x_q <= dat_w[17:0];
            end
        end
    end

    assign req.func = func_q;
    assign req.x    = x_q;

    // Sticky done and captured result
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_flag <= 1'b0;
            result_q  <= '0;
        end else begin
            if (start) begin
                done_flag <= 1'b0;
            end else if (done) begin
                done_flag <= 1'b1;
            end
            if (done) begin
                result_q <= result;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read path, data returned with ack
    // ------------------------------------------------------------------------

    always_comb begin
        rd_data = '0;
        case (adr)
            REG_CTRL:   rd_data[2:0] = func_q;
            REG_X:      rd_data = 32'(x_q);
            REG_STATUS: begin
                rd_data[STAT_BUSY_BIT] = busy;
                rd_data[STAT_DONE_BIT] = done_flag;
            end
            default:    rd_data = 32'(result_q);
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dat_r <= '0;
        end else if (bus_req) begin
            dat_r <= rd_data;
        end
    end

endmodule

// ==== hw/taylor_sequencer.sv ====
`timescale 1ns/1ps

module taylor_sequencer
    import taylor_pkg::*;
#(
    parameter int ACC_W = 48
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  calc_req_t  req,
    input  fix_t       coef,
    input  fix_t       recip,
    output logic [3:0] coef_idx,
    output mac_in_t    mac_in,
    input  mac_out_t   mac_out,
    output logic       busy,
    output logic       done,
    output fix_t       result
);

    // ------------------------------------------------------------------------
    // Microcode task flags
    // ------------------------------------------------------------------------

    localparam logic [12:0] T_NOP       = 13'h0000;
    localparam logic [12:0] T_WAIT_IN   = 13'h0001;
    localparam logic [12:0] T_MUL_X_R   = 13'h0002;
    localparam logic [12:0] T_MUL_T_R   = 13'h0004;
    localparam logic [12:0] T_MADD_T_C  = 13'h0008;
    localparam logic [12:0] T_MOV_I_0   = 13'h0010;
    localparam logic [12:0] T_MOV_J_1   = 13'h0020;
    localparam logic [12:0] T_INC_I     = 13'h0040;
    localparam logic [12:0] T_INC_J     = 13'h0080;
    localparam logic [12:0] T_REPEAT_10 = 13'h0100;
    localparam logic [12:0] T_MOV_RES   = 13'h0200;
    localparam logic [12:0] T_JP_0      = 13'h0400;
    localparam logic [12:0] T_JP_3      = 13'h0800;
    localparam logic [12:0] T_JP_7      = 13'h1000;

    localparam logic [3:0] PC_IDLE  = 4'h0;
    localparam logic [3:0] PC_PH2   = 4'h3;
    localparam logic [3:0] PC_PH3   = 4'h7;
    localparam logic [3:0] END_IDX  = 4'(N_TERMS + 1);
    localparam logic [3:0] RPT_LAST = 4'(N_TERMS - 1);

    // Pending write of a slice result into r or term
    typedef struct packed {
        logic       en;
        logic       to_term;
        logic [3:0] idx;
    } wb_tag_t;

    logic [3:0]              pc;
    logic [12:0]             tasks;
    logic [3:0]              rpt_cnt;
    logic [3:0]              i_reg;
    logic [3:0]              j_reg;
    fix_t                    x_reg;
    fix_t                    r_mem [0:N_TERMS];
    fix_t                    t_mem [0:N_TERMS];
    wb_tag_t                 wb_issue;
    wb_tag_t [2:0]           wb_pipe;
    logic signed [ACC_W-1:0] acc_fb;
    fix_t                    p_fix;
    fix_t                    term_rd;
    logic                    hold;

    // Phase 1 at pc 1, phase 2 loops on 3..5, phase 3 loops on 7..9
    always_comb begin
        case (pc)
            4'h0:    tasks = T_WAIT_IN | T_MOV_I_0 | T_MOV_J_1;
            4'h1:    tasks = T_REPEAT_10 | T_MUL_X_R | T_INC_J;
            4'h2:    tasks = T_MOV_I_0 | T_MOV_J_1;
            4'h3:    tasks = T_MUL_T_R | T_INC_I | T_INC_J;
            4'h4:    tasks = T_NOP;
            4'h5:    tasks = (j_reg != END_IDX) ? T_JP_3 : T_NOP;
            4'h6:    tasks = T_MOV_I_0;
            4'h7:    tasks = T_MADD_T_C | T_INC_I;
            4'h8:    tasks = T_NOP;
            4'h9:    tasks = (i_reg != END_IDX) ? T_JP_7 : T_NOP;
            4'ha:    tasks = T_MOV_RES | T_JP_0;
            default: tasks = T_JP_0;
        endcase
    end

    assign hold = (|(tasks & T_WAIT_IN) && !start) ||
                  (|(tasks & T_REPEAT_10) && (rpt_cnt != RPT_LAST));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= PC_IDLE;
        end else if (|(tasks & T_JP_0)) begin
            pc <= PC_IDLE;
        end else if (|(tasks & T_JP_3)) begin
            pc <= PC_PH2;
        end else if (|(tasks & T_JP_7)) begin
            pc <= PC_PH3;
        end else if (!hold) begin
            pc <= pc + 4'h1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rpt_cnt <= '0;
        end else if (|(tasks & T_REPEAT_10) && (rpt_cnt != RPT_LAST)) begin
            rpt_cnt <= rpt_cnt + 4'h1;
        end else begin
            rpt_cnt <= '0;
        end
    end

    // Index registers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            i_reg <= '0;
            j_reg <= '0;
        end else begin
            if (|(tasks & T_MOV_I_0)) begin
                i_reg <= '0;
            end else if (|(tasks & T_INC_I)) begin
                i_reg <= i_reg + 4'h1;
            end
            if (|(tasks & T_MOV_J_1)) begin
                j_reg <= 4'h1;
            end else if (|(tasks & T_INC_J)) begin
                j_reg <= j_reg + 4'h1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|(tasks & T_WAIT_IN) && start) begin
            x_reg <= req.x;
        end
    end

    // ------------------------------------------------------------------------
    // Write-back aligned to the slice latency
    // ------------------------------------------------------------------------

    assign acc_fb = ACC_W'(mac_out.p);
    assign p_fix  = acc_fb[33:16];

    assign wb_issue.en      = |(tasks & (T_MUL_X_R | T_MUL_T_R));
    assign wb_issue.to_term = |(tasks & T_MUL_T_R);
    assign wb_issue.idx     = j_reg;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_pipe <= '0;
        end else begin
            wb_pipe <= {wb_pipe[1:0], wb_issue};
        end
    end

    always_ff @(posedge clk) begin
        if (|(tasks & T_WAIT_IN)) begin
            t_mem[0] <= FIX_ONE;
        end
        if (wb_pipe[2].en) begin
            if (wb_pipe[2].to_term) begin
                t_mem[wb_pipe[2].idx] <= p_fix;
            end else begin
                r_mem[wb_pipe[2].idx] <= p_fix;
            end
        end
    end

    // Forward the term that is being written this cycle
    assign term_rd = (wb_pipe[2].en && wb_pipe[2].to_term && (wb_pipe[2].idx == i_reg)) ?
                     p_fix : t_mem[i_reg];

    // ------------------------------------------------------------------------
    // Slice operands
    // ------------------------------------------------------------------------

    assign coef_idx = |(tasks & T_MUL_X_R) ? j_reg : i_reg;

    always_comb begin
        mac_in    = '0;
        mac_in.op = MAC_NOP;
        if (|(tasks & T_MUL_X_R)) begin
            mac_in.op = MAC_MUL;
            mac_in.a  = x_reg;
            mac_in.b  = recip;
        end else if (|(tasks & T_MUL_T_R)) begin
            mac_in.op = MAC_MUL;
            mac_in.a  = term_rd;
            mac_in.b  = r_mem[j_reg];
        end else if (|(tasks & T_MADD_T_C)) begin
            mac_in.op = MAC_MADD;
            mac_in.a  = term_rd;
            mac_in.b  = coef;
            // First order starts the sum from zero
            mac_in.c  = (i_reg == 4'h0) ? '0 : mac_word_t'(acc_fb);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= |(tasks & T_MOV_RES);
            if (|(tasks & T_MOV_RES)) begin
                result <= p_fix;
            end
        end
    end

    assign busy = (pc != PC_IDLE);

endmodule

// ==== hw/dsp_mac.sv ====
`timescale 1ns/1ps

module dsp_mac
    import taylor_pkg::*;
#(
    parameter int ACC_W = 48
) (
    input  logic     clk,
    input  logic     reset,
    input  mac_in_t  mac_in,
    output mac_out_t mac_out
);

    mac_op_e                 op_s1;
    mac_op_e                 op_s2;
    fix_t                    a_s1;
    fix_t                    b_s1;
    mac_word_t               c_s1;
    mac_word_t               c_s2;
    logic signed [35:0]      prod_s2;
    logic signed [ACC_W-1:0] acc;

    // Opcode travels with the data
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_s1 <= MAC_NOP;
            op_s2 <= MAC_NOP;
        end else begin
            op_s1 <= mac_in.op;
            op_s2 <= op_s1;
        end
    end

    // Input and product stages, c kept in step with the product
    always_ff @(posedge clk) begin
        a_s1    <= mac_in.a;
        b_s1    <= mac_in.b;
        c_s1    <= mac_in.c;
        prod_s2 <= a_s1 * b_s1;
        c_s2    <= c_s1;
    end

    // Accumulator stage at full precision
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc <= '0;
        end else begin
            case (op_s2)
                MAC_MUL:  acc <= ACC_W'(prod_s2);
                MAC_MADD: acc <= ACC_W'(prod_s2) + ACC_W'(c_s2);
                MAC_CLR:  acc <= '0;
                default:  acc <= acc;
            endcase
        end
    end

    assign mac_out.p = mac_word_t'(acc);

endmodule

// ==== hw/taylor_coef_rom.sv ====
`timescale 1ns/1ps

module taylor_coef_rom
    import taylor_pkg::*;
(
    input  func_e      func,
    input  logic [3:0] idx,
    output fix_t       coef,
    output fix_t       recip
);

    localparam fix_t FIX_MINUS_ONE = -FIX_ONE;

    // Sign of the derivative at zero, per function and order
    always_comb begin
        case (func)
            FN_SIN: begin
                case (idx[1:0])
                    2'd1:    coef = FIX_ONE;
                    2'd3:    coef = FIX_MINUS_ONE;
                    default: coef = '0;
                endcase
            end
            FN_COS: begin
                case (idx[1:0])
                    2'd0:    coef = FIX_ONE;
                    2'd2:    coef = FIX_MINUS_ONE;
                    default: coef = '0;
                endcase
            end
            FN_SINH: coef = idx[0] ? FIX_ONE : '0;
            FN_COSH: coef = idx[0] ? '0 : FIX_ONE;
            default: coef = '0;
        endcase
        // Nothing beyond the last order
        if (idx > 4'(N_TERMS)) begin
            coef = '0;
        end
    end

    // 1/n truncated, 1.0 at n = 0
    always_comb begin
        case (idx)
            4'd0:    recip = 18'sh10000;
            4'd1:    recip = 18'sh10000;
            4'd2:    recip = 18'sh08000;
            4'd3:    recip = 18'sh05555;
            4'd4:    recip = 18'sh04000;
            4'd5:    recip = 18'sh03333;
            4'd6:    recip = 18'sh02aaa;
            4'd7:    recip = 18'sh02492;
            4'd8:    recip = 18'sh02000;
            4'd9:    recip = 18'sh01c71;
            4'd10:   recip = 18'sh01999;
            default: recip = '0;
        endcase
    end

endmodule

// ==== hw/taylor_pkg.sv ====
package taylor_pkg;

    // ------------------------------------------------------------------------
    // Fixed-point format
    // ------------------------------------------------------------------------

    // Signed Q2.16
    typedef logic signed [17:0] fix_t;

    localparam fix_t FIX_ONE = 18'sh10000;

    // Highest order of the series
    localparam int N_TERMS = 10;

    // ------------------------------------------------------------------------
    // Multiply-accumulate slice interface
    // ------------------------------------------------------------------------

    typedef logic signed [47:0] mac_word_t;

    typedef enum logic [1:0] {
        MAC_NOP  = 2'd0,
        MAC_MUL  = 2'd1,
        MAC_MADD = 2'd2,
        MAC_CLR  = 2'd3
    } mac_op_e;

    typedef struct packed {
        mac_op_e   op;
        fix_t      a;
        fix_t      b;
        mac_word_t c;
    } mac_in_t;

    typedef struct packed {
        mac_word_t p;
    } mac_out_t;

    // ------------------------------------------------------------------------
    // Function select and register map
    // ------------------------------------------------------------------------

    // Codes 4 to 7 are reserved
    typedef enum logic [2:0] {
        FN_SIN  = 3'd0,
        FN_COS  = 3'd1,
        FN_SINH = 3'd2,
        FN_COSH = 3'd3
    } func_e;

    typedef struct packed {
        func_e func;
        fix_t  x;
    } calc_req_t;

    // Word offsets on adr[3:2]
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_X      = 2'd1;
    localparam logic [1:0] REG_STATUS = 2'd2;
    localparam logic [1:0] REG_RESULT = 2'd3;

    localparam int CTRL_START_BIT = 8;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;

endpackage
